//--- Makefile
# Verilator simulation of the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dm_cache
FILELIST  ?= dm_cache.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

//--- dm_cache.f
verilog/dm_cache_pkg.sv
verilog/cache_line_if.sv
verilog/cache_line.sv
verilog/cache_ctrl.sv
verilog/line_select.sv
verilog/dm_cache.sv
test/tb_dm_cache.sv

//--- test/tb_dm_cache.sv
//////////////////////////////
// random-stimulus testbench for the data cache, with a slow
// block memory responder and a word model of memory contents
//////////////////////////////

module tb_dm_cache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TB_LINES     = 8;
    localparam int          NUM_BLOCKS   = 32;      // small space, frequent conflicts
    localparam int          WPB          = dm_cache_pkg::WORDS_PER_BLOCK;
    localparam int          NUM_ACCESSES = 2000;
    localparam int          TIMEOUT      = 200;
    localparam logic [15:0] SEED         = 16'd58700;

    logic                       clk;
    logic                       rst_n;
    logic                       proc_read_i;
    logic                       proc_write_i;
    dm_cache_pkg::word_addr_t   proc_addr_i;
    dm_cache_pkg::word_t        proc_wdata_i;
    logic                       proc_stall_o;
    dm_cache_pkg::word_t        proc_rdata_o;
    logic                       mem_read_o;
    logic                       mem_write_o;
    dm_cache_pkg::block_addr_t  mem_addr_o;
    dm_cache_pkg::block_t       mem_wdata_o;
    dm_cache_pkg::block_t       mem_rdata_i;
    logic                       mem_ready_i;

    // golden words, only changed by completed processor writes
    dm_cache_pkg::word_t        golden [NUM_BLOCKS*WPB];
    logic                       ever_written [NUM_BLOCKS];
    dm_cache_pkg::block_t       mem_blocks [NUM_BLOCKS];
    logic [15:0]                main_lfsr;
    logic [15:0]                mem_lfsr;      // responder has its own stream

    // which block each line should hold, -1 when empty
    int                         resident [TB_LINES];
    logic                       dirty_m [TB_LINES];

    dm_cache #(
        .NUM_LINES (TB_LINES)
    ) i_dm_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_read_i  (proc_read_i),
        .proc_write_i (proc_write_i),
        .proc_addr_i  (proc_addr_i),
        .proc_wdata_i (proc_wdata_i),
        .proc_stall_o (proc_stall_o),
        .proc_rdata_o (proc_rdata_o),
        .mem_read_o   (mem_read_o),
        .mem_write_o  (mem_write_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ready_i  (mem_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // random numbers
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(inout logic [15:0] state, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            v     = {v[30:0], state[0]};   // one step per bit
        end
        return v;
    endfunction

    function automatic dm_cache_pkg::block_t golden_block(input int blk);
        dm_cache_pkg::block_t b;
        for (int w = 0; w < WPB; w++) begin
            b[w] = golden[blk*WPB + w];
        end
        return b;
    endfunction

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("Error: %s expected 0x%h, actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input dm_cache_pkg::word_t exp,
                              input dm_cache_pkg::word_t act);
        if (act !== exp) begin
            fail_now($sformatf("Error: %s expected 0x%h, actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_block(input string name, input dm_cache_pkg::block_t exp,
                               input dm_cache_pkg::block_t act);
        if (act !== exp) begin
            fail_now($sformatf("Error: %s expected 0x%h, actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_block_addr(input string name, input dm_cache_pkg::block_addr_t exp,
                                    input dm_cache_pkg::block_addr_t act);
        if (act !== exp) begin
            fail_now($sformatf("Error: %s expected 0x%h, actual 0x%h", name, exp, act));
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && mem_read_o && mem_write_o) begin
            fail_now("memory read and write were requested in the same cycle");
        end
    end

    //////////////////////////////
    // memory responder
    //////////////////////////////

    initial begin : memory_responder
        int                         delay;
        int                         blk;
        logic                       is_write;
        dm_cache_pkg::block_addr_t  addr;
        dm_cache_pkg::block_t       wblock;

        mem_ready_i <= 1'b0;
        mem_rdata_i <= '0;
        mem_lfsr     = SEED;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int w = 0; w < WPB; w++) begin
                mem_blocks[b][w] = take_bits(mem_lfsr, 32);
            end
        end
        forever begin
            @(negedge clk);
            if (rst_n && (mem_read_o || mem_write_o)) begin
                is_write = mem_write_o;
                addr     = mem_addr_o;
                wblock   = mem_wdata_o;
                if (int'(addr) >= NUM_BLOCKS) begin
                    fail_now("memory request outside the tested block range");
                end
                blk   = int'(addr);
                delay = 1 + int'(take_bits(mem_lfsr, 2));
                for (int k = 1; k <= delay; k++) begin
                    @(posedge clk);
                    if (k == delay) begin
                        mem_ready_i <= 1'b1;
                        if (!is_write) begin
                            mem_rdata_i <= mem_blocks[blk];
                        end
                    end
                    @(negedge clk);
                    // request held until the ready cycle
                    check_bit("mem_read_o", !is_write, mem_read_o);
                    check_bit("mem_write_o", is_write, mem_write_o);
                    check_block_addr("mem_addr_o", addr, mem_addr_o);
                    if (is_write) begin
                        check_block("mem_wdata_o", wblock, mem_wdata_o);
                    end
                end
                if (is_write) begin
                    if (!ever_written[blk]) begin
                        fail_now("write-back of a block that was never written");
                    end
                    check_block("mem_wdata_o", golden_block(blk), wblock);
                    mem_blocks[blk] = wblock;
                end
                @(posedge clk);
                mem_ready_i <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // processor stimulus
    //////////////////////////////

    initial begin : stimulus
        int                         blk;
        int                         idx;
        int                         cycles;
        logic                       is_write;
        logic                       miss;
        dm_cache_pkg::offset_t      off;
        dm_cache_pkg::word_t        wdata;
        dm_cache_pkg::block_addr_t  exp_addr;

        rst_n        <= 1'b0;
        proc_read_i  <= 1'b0;
        proc_write_i <= 1'b0;
        proc_addr_i  <= '0;
        proc_wdata_i <= '0;
        main_lfsr     = SEED;     // same fill as the memory
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            ever_written[b] = 1'b0;
            for (int w = 0; w < WPB; w++) begin
                golden[b*WPB + w] = take_bits(main_lfsr, 32);
            end
        end
        for (int i = 0; i < TB_LINES; i++) begin
            resident[i] = -1;
            dirty_m[i]  = 1'b0;
        end
        blk = 0;
        off = '0;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("mem_read_o", 1'b0, mem_read_o);
        check_bit("mem_write_o", 1'b0, mem_write_o);

        for (int n = 0; n < NUM_ACCESSES; n++) begin
            @(posedge clk);
            // one access in four repeats the last address
            if (n == 0 || take_bits(main_lfsr, 2) != 0) begin
                blk = int'(take_bits(main_lfsr, 5));
                off = dm_cache_pkg::offset_t'(take_bits(main_lfsr, 2));
            end
            is_write     = 1'(take_bits(main_lfsr, 1));
            wdata        = take_bits(main_lfsr, 32);
            proc_read_i  <= !is_write;
            proc_write_i <= is_write;
            proc_addr_i  <= dm_cache_pkg::word_addr_t'(blk*WPB + int'(off));
            proc_wdata_i <= wdata;
            idx  = blk % TB_LINES;
            miss = (resident[idx] != blk);

            @(negedge clk);
            check_bit("proc_stall_o", miss, proc_stall_o);     // hits never stall
            if (miss) begin
                @(negedge clk);
                // a dirty victim goes out before the refill
                exp_addr = dirty_m[idx] ? dm_cache_pkg::block_addr_t'(resident[idx])
                                        : dm_cache_pkg::block_addr_t'(blk);
                check_bit("mem_write_o", dirty_m[idx], mem_write_o);
                check_bit("mem_read_o", !dirty_m[idx], mem_read_o);
                check_block_addr("mem_addr_o", exp_addr, mem_addr_o);
            end
            cycles = 0;
            while (proc_stall_o) begin
                if (cycles == TIMEOUT) begin
                    fail_now("access did not complete within 200 cycles");
                end
                cycles++;
                @(negedge clk);
            end

            // completing cycle
            if (is_write) begin
                golden[blk*WPB + int'(off)] = wdata;
                ever_written[blk]           = 1'b1;
            end else begin
                check_word("proc_rdata_o", golden[blk*WPB + int'(off)], proc_rdata_o);
            end
            if (miss) begin
                resident[idx] = blk;
                dirty_m[idx]  = 1'b0;
            end
            if (is_write) begin
                dirty_m[idx] = 1'b1;
            end
        end

        @(posedge clk);
        proc_read_i  <= 1'b0;
        proc_write_i <= 1'b0;
        @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- verilog/cache_ctrl.sv
//////////////////////////////
// miss handling FSM of the data cache, drives the line
// updates, the processor stall and the block memory request
//////////////////////////////

module cache_ctrl #(
    parameter  int NUM_LINES = 8,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = dm_cache_pkg::ADDR_W - dm_cache_pkg::OFFSET_W - IDX_W
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // processor side
    input  logic                       proc_read_i,
    input  logic                       proc_write_i,
    input  dm_cache_pkg::word_addr_t   proc_addr_i,
    input  dm_cache_pkg::word_t        proc_wdata_i,
    output logic                       proc_stall_o,

    // memory side
    input  dm_cache_pkg::block_t       mem_rdata_i,
    input  logic                       mem_ready_i,
    output logic                       mem_read_o,
    output logic                       mem_write_o,
    output dm_cache_pkg::block_addr_t  mem_addr_o,
    output dm_cache_pkg::block_t       mem_wdata_o,

    // status of the indexed line
    input  logic                       hit_i,
    input  logic                       dirty_i,
    input  logic [TAG_W-1:0]           victim_tag_i,
    input  dm_cache_pkg::block_t       victim_block_i,

    cache_line_if.ctrl                 lines [NUM_LINES]
);

    logic [TAG_W-1:0]             req_tag;
    logic [IDX_W-1:0]             req_idx;
    dm_cache_pkg::offset_t        req_off;
    logic                         access;
    logic                         do_write;
    logic                         do_fill;
    dm_cache_pkg::ctrl_state_e    state_q;
    dm_cache_pkg::ctrl_state_e    state_d;

    assign {req_tag, req_idx, req_off} = proc_addr_i;
    assign access = proc_read_i || proc_write_i;

    //////////////////////////////
    // line control
    //////////////////////////////

    // request fields go to every line, strobes only to the indexed one
    for (genvar i = 0; i < NUM_LINES; i++) begin : g_line_ctrl
        assign lines[i].sel        = (req_idx == IDX_W'(i));
        assign lines[i].wr_word    = (req_idx == IDX_W'(i)) && do_write;
        assign lines[i].fill       = (req_idx == IDX_W'(i)) && do_fill;
        assign lines[i].req_tag    = req_tag;
        assign lines[i].req_offset = req_off;
        assign lines[i].wdata      = proc_wdata_i;
        assign lines[i].fill_block = mem_rdata_i;
    end

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dm_cache_pkg::S_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // next state and outputs
    //////////////////////////////

    always_comb begin
        state_d     = state_q;
        do_write    = 1'b0;
        do_fill     = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        mem_addr_o  = {req_tag, req_idx};

        case (state_q)
            dm_cache_pkg::S_LOOKUP: begin
                if (access && hit_i) begin
                    do_write = proc_write_i;    // hit write merges at the edge
                end else if (access) begin
                    // a clean or empty victim can be overwritten right away
                    state_d = dirty_i ? dm_cache_pkg::S_WRITEBACK
                                      : dm_cache_pkg::S_REFILL;
                end
            end

            dm_cache_pkg::S_WRITEBACK: begin
                mem_write_o = 1'b1;
                mem_addr_o  = {victim_tag_i, req_idx};   // victim's own block
                if (mem_ready_i) begin
                    state_d = dm_cache_pkg::S_REFILL;
                end
            end

            dm_cache_pkg::S_REFILL: begin
                mem_read_o = 1'b1;
                if (mem_ready_i) begin
                    do_fill = 1'b1;                      // rdata valid this cycle
                    state_d = dm_cache_pkg::S_LOOKUP;
                end
            end

            default: begin
                state_d = dm_cache_pkg::S_LOOKUP;
            end
        endcase
    end

    // victim stays untouched until the fill, so its block is stable
    assign mem_wdata_o = victim_block_i;

    // the refilled access hits once back in lookup
    assign proc_stall_o = (state_q != dm_cache_pkg::S_LOOKUP) || (access && !hit_i);

endmodule

//--- verilog/cache_line.sv
//////////////////////////////
// one direct-mapped line with valid, dirty, tag and data
// updated by the controller, read out through the selector
//////////////////////////////

module cache_line (
    input  logic        clk,
    input  logic        rst_n,
    cache_line_if.line  lif
);

    logic valid_q;

    //////////////////////////////
    // status bits
    //////////////////////////////

    // a fill always brings a clean copy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            lif.dirty <= 1'b0;
        end else if (lif.fill) begin
            valid_q   <= 1'b1;
            lif.dirty <= 1'b0;
        end else if (lif.wr_word) begin
            lif.dirty <= 1'b1;          // line now differs from memory
        end
    end

    //////////////////////////////
    // tag and data storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (lif.fill) begin
            lif.tag_q  <= lif.req_tag;
            lif.data_q <= lif.fill_block;
        end else if (lif.wr_word) begin
            // only the addressed word changes, the rest is kept
            lif.data_q[lif.req_offset] <= lif.wdata;
        end
    end

    //////////////////////////////
    // tag compare
    //////////////////////////////

    // unselected lines never report a hit
    assign lif.hit = lif.sel && valid_q && (lif.tag_q == lif.req_tag);

endmodule

//--- verilog/cache_line_if.sv
//////////////////////////////
// control and status of one cache line, shared by the
// controller, the line itself and the line selector
//////////////////////////////

interface cache_line_if #(
    parameter int NUM_LINES = 8
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = dm_cache_pkg::ADDR_W - dm_cache_pkg::OFFSET_W - IDX_W;

    // from the controller
    logic                    sel;          // indexed by the current address
    logic                    wr_word;      // merge wdata at req_offset
    logic                    fill;         // load fill_block and req_tag
    logic [TAG_W-1:0]        req_tag;
    dm_cache_pkg::offset_t   req_offset;
    dm_cache_pkg::word_t     wdata;
    dm_cache_pkg::block_t    fill_block;

    // from the line
    logic                    hit;
    logic                    dirty;
    logic [TAG_W-1:0]        tag_q;
    dm_cache_pkg::block_t    data_q;

    modport ctrl (
        output sel, wr_word, fill, req_tag, req_offset, wdata, fill_block
    );

    modport line (
        input  sel, wr_word, fill, req_tag, req_offset, wdata, fill_block,
        output hit, dirty, tag_q, data_q
    );

    modport select (
        input hit, dirty, tag_q, data_q
    );

endinterface

//--- verilog/dm_cache.sv
//////////////////////////////
// direct-mapped write-back data cache, word port to the
// processor and block port to a slow memory
//////////////////////////////

module dm_cache #(
    parameter int NUM_LINES = 8     // 4, 8 or 16
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // processor side
    input  logic                       proc_read_i,
    input  logic                       proc_write_i,
    input  dm_cache_pkg::word_addr_t   proc_addr_i,
    input  dm_cache_pkg::word_t        proc_wdata_i,
    output logic                       proc_stall_o,
    output dm_cache_pkg::word_t        proc_rdata_o,

    // memory side
    output logic                       mem_read_o,
    output logic                       mem_write_o,
    output dm_cache_pkg::block_addr_t  mem_addr_o,
    output dm_cache_pkg::block_t       mem_wdata_o,
    input  dm_cache_pkg::block_t       mem_rdata_i,
    input  logic                       mem_ready_i
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = dm_cache_pkg::ADDR_W - dm_cache_pkg::OFFSET_W - IDX_W;

    // indexed line status, selector to controller
    logic                   sel_hit;
    logic                   sel_dirty;
    logic [TAG_W-1:0]       sel_tag;
    dm_cache_pkg::block_t   sel_block;

    cache_line_if #(.NUM_LINES(NUM_LINES)) line_if [NUM_LINES] ();

    //////////////////////////////
    // controller
    //////////////////////////////

    cache_ctrl #(
        .NUM_LINES (NUM_LINES)
    ) i_cache_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .proc_read_i    (proc_read_i),
        .proc_write_i   (proc_write_i),
        .proc_addr_i    (proc_addr_i),
        .proc_wdata_i   (proc_wdata_i),
        .proc_stall_o   (proc_stall_o),
        .mem_rdata_i    (mem_rdata_i),
        .mem_ready_i    (mem_ready_i),
        .mem_read_o     (mem_read_o),
        .mem_write_o    (mem_write_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .hit_i          (sel_hit),
        .dirty_i        (sel_dirty),
        .victim_tag_i   (sel_tag),
        .victim_block_i (sel_block),
        .lines          (line_if)
    );

    //////////////////////////////
    // line storage
    //////////////////////////////

    for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
        cache_line i_cache_line (
            .clk   (clk),
            .rst_n (rst_n),
            .lif   (line_if[i])
        );
    end

    //////////////////////////////
    // read path
    //////////////////////////////

    line_select #(
        .NUM_LINES (NUM_LINES)
    ) i_line_select (
        .proc_addr_i    (proc_addr_i),
        .lines          (line_if),
        .hit_o          (sel_hit),
        .dirty_o        (sel_dirty),
        .victim_tag_o   (sel_tag),
        .victim_block_o (sel_block),
        .rdata_o        (proc_rdata_o)
    );

endmodule

//--- verilog/dm_cache_pkg.sv
//////////////////////////////
// shared widths, data types and controller states of the
// direct-mapped write-back data cache, referenced by scoped names
//////////////////////////////

package dm_cache_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
    localparam int ADDR_W          = 30;   // word address, byte bits dropped
    localparam int OFFSET_W        = $clog2(WORDS_PER_BLOCK);

    //////////////////////////////
    // data types
    //////////////////////////////
    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the low bits of the block
    typedef word_t [WORDS_PER_BLOCK-1:0] block_t;

    typedef logic [ADDR_W-1:0] word_addr_t;

    typedef logic [ADDR_W-OFFSET_W-1:0] block_addr_t;   // tag and index

    typedef logic [OFFSET_W-1:0] offset_t;

    //////////////////////////////
    // miss handling states
    //////////////////////////////
    typedef enum logic [1:0] {
        S_LOOKUP,       // idle or serving hits
        S_WRITEBACK,    // dirty victim going out
        S_REFILL        // requested block coming in
    } ctrl_state_e;

endpackage

//--- verilog/line_select.sv
//////////////////////////////
// picks the indexed line's status and block for the controller
// and extracts the addressed word as read data
//////////////////////////////

module line_select #(
    parameter  int NUM_LINES = 8,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = dm_cache_pkg::ADDR_W - dm_cache_pkg::OFFSET_W - IDX_W
) (
    input  dm_cache_pkg::word_addr_t  proc_addr_i,
    cache_line_if.select              lines [NUM_LINES],
    output logic                      hit_o,
    output logic                      dirty_o,
    output logic [TAG_W-1:0]          victim_tag_o,
    output dm_cache_pkg::block_t      victim_block_o,
    output dm_cache_pkg::word_t       rdata_o
);

    logic [NUM_LINES-1:0]   hit_v;
    logic [NUM_LINES-1:0]   dirty_v;
    logic [TAG_W-1:0]       tag_v   [NUM_LINES];
    dm_cache_pkg::block_t   block_v [NUM_LINES];
    logic [IDX_W-1:0]       idx;
    dm_cache_pkg::offset_t  off;

    // interface arrays only take constant indices, gather first
    for (genvar i = 0; i < NUM_LINES; i++) begin : g_gather
        assign hit_v[i]   = lines[i].hit;
        assign dirty_v[i] = lines[i].dirty;
        assign tag_v[i]   = lines[i].tag_q;
        assign block_v[i] = lines[i].data_q;
    end

    assign idx = proc_addr_i[dm_cache_pkg::OFFSET_W +: IDX_W];
    assign off = proc_addr_i[dm_cache_pkg::OFFSET_W-1:0];

    assign hit_o          = hit_v[idx];
    assign dirty_o        = dirty_v[idx];
    assign victim_tag_o   = tag_v[idx];
    assign victim_block_o = block_v[idx];
    assign rdata_o        = block_v[idx][off];   // meaningful on a hit only

endmodule
